/* Bender.yml */
package:
  name: osd_ctrl

sources:
  # shared package first
  - common/osd_pkg.sv
  # spi side
  - spi_cmd/spi_byte_rx.sv
  - spi_cmd/osd_cmd_decoder.sv
  # video side
  - osd_video/osd_beam_timing.sv
  - osd_video/osd_pixel_out.sv
  # top level
  - logic/osd_ctrl.sv
  # testbench
  - target: test
    files:
      - bench/osd_ctrl_tb.sv

/* bench/osd_ctrl_tb.sv */
// osd controller testbench: spi register and buffer writes, overlay scan checks
`timescale 1ns/1ns

module osd_ctrl_tb;

  // ----------------------------------------------------------------------
  // beam format, window and spi timing
  // ----------------------------------------------------------------------

  localparam int line_cycles  = 1024;
  localparam int frame_lines  = 312;
  localparam int frame_cycles = line_cycles * frame_lines;
  localparam int win_v_start  = 128;
  localparam int win_height   = 64;
  localparam int win_width    = 256;
  // sck half period in clk cycles
  localparam int sck_half     = 5;
  localparam int buf_bytes    = 2048;
  localparam int max_rows     = 16;
  // table rows, buffer payload and ten frames of scanning
  localparam int watchdog_cycles =
    (max_rows * 200 + buf_bytes * 8) * 2 * sck_half + 10 * frame_cycles;

  logic       clk;
  logic       reset;
  logic       spi_cs_n;
  logic       spi_sck;
  logic       spi_sdi;
  logic       sol;
  logic       sof;
  logic       usrrst;
  logic       osd_enable;
  logic       key_disable;
  logic [4:0] chipset_config;
  logic [6:0] memory_config;
  logic [1:0] scanline;
  logic [1:0] lr_filter;
  logic [1:0] hr_filter;
  logic [1:0] dither;
  logic [3:0] floppy_config;
  logic       osd_blank;
  logic       osd_pixel;

  // stimulus table
  string      row_name [max_rows];
  logic [7:0] row_cmd  [max_rows];
  logic [7:0] row_d0   [max_rows];
  logic [7:0] row_d1   [max_rows];
  int         row_len  [max_rows];
  logic [7:0] row_exp  [max_rows];
  int         row_cnt;

  // expected config word, same packing as cfg_now
  logic [26:0] cfg_exp;
  // mirror of the character buffer
  logic [7:0]  exp_buf [buf_bytes];
  logic [31:0] rng;

  int reg_errors;
  int pixel_errors;
  int blank_errors;
  // 0 blank must stay low, 1 full window expected, 2 not checked
  int scan_mode;
  int frame_mode;
  int frame_cnt;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  osd_ctrl u_osd_ctrl (
    .clk            (clk),
    .reset          (reset),
    .spi_cs_n       (spi_cs_n),
    .spi_sck        (spi_sck),
    .spi_sdi        (spi_sdi),
    .sol            (sol),
    .sof            (sof),
    .usrrst         (usrrst),
    .osd_enable     (osd_enable),
    .key_disable    (key_disable),
    .chipset_config (chipset_config),
    .memory_config  (memory_config),
    .scanline       (scanline),
    .lr_filter      (lr_filter),
    .hr_filter      (hr_filter),
    .dither         (dither),
    .floppy_config  (floppy_config),
    .osd_blank      (osd_blank),
    .osd_pixel      (osd_pixel)
  );

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // all configuration outputs in one word
  function automatic logic [26:0] cfg_now();
    return {usrrst, key_disable, osd_enable, chipset_config, memory_config,
            dither, hr_filter, lr_filter, scanline, floppy_config};
  endfunction

  // place a field value where its command puts it
  function automatic logic [26:0] apply_field(input logic [26:0] cur,
                                              input logic [7:0]  cmd,
                                              input logic [7:0]  val);
    logic [26:0] r;
    r = cur;
    case (cmd[7:2])
      6'b000010: r[26]    = val[0];
      // key disable above enable
      6'b010010: r[25:24] = val[1:0];
      6'b000001: r[23:19] = val[4:0];
      6'b001001: r[18:12] = val[6:0];
      // dither, hr, lr, scanline from bit 7 down
      6'b001101: r[11:4]  = val;
      6'b010001: r[3:0]   = val[3:0];
      default:   ;
    endcase
    return r;
  endfunction

  task automatic add_row(input string name, input logic [7:0] cmd, input logic [7:0] d0,
                         input logic [7:0] d1, input int len, input logic [7:0] exp_val);
    row_name[row_cnt] = name;
    row_cmd[row_cnt]  = cmd;
    row_d0[row_cnt]   = d0;
    row_d1[row_cnt]   = d1;
    row_len[row_cnt]  = len;
    row_exp[row_cnt]  = exp_val;
    row_cnt++;
  endtask

  task automatic spi_select();
    @(negedge clk);
    spi_cs_n = 1'b0;
  endtask

  task automatic spi_deselect();
    repeat (sck_half) @(negedge clk);
    spi_cs_n = 1'b1;
    // gap lets frame_end and the last register load settle
    repeat (4 * sck_half) @(negedge clk);
  endtask

  // msb first, receiver samples on the rising sck edge
  task automatic spi_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      spi_sdi = b[i];
      repeat (sck_half) @(negedge clk);
      spi_sck = 1'b1;
      repeat (sck_half) @(negedge clk);
      spi_sck = 1'b0;
    end
  endtask

  task automatic check_config(input string name, input logic [26:0] expected);
    if (cfg_now() !== expected) begin
      reg_errors++;
      $display("mismatch %s: expected %h actual %h", name, expected, cfg_now());
    end
  endtask

  task automatic send_reg(input string name, input logic [7:0] cmd, input logic [7:0] data,
                          input logic [7:0] exp_val);
    spi_select();
    spi_byte(cmd);
    spi_byte(data);
    spi_deselect();
    cfg_exp = apply_field(cfg_exp, cmd, exp_val);
    check_config(name, cfg_exp);
  endtask

  // random bytes from start, address wraps at the buffer end
  task automatic write_payload(input logic [10:0] start);
    logic [10:0] addr;
    addr = start;
    for (int k = 0; k < buf_bytes; k++) begin
      rng = xorshift32(rng);
      exp_buf[addr] = rng[7:0];
      spi_byte(rng[7:0]);
      addr = addr + 11'd1;
    end
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = frame_cnt + n;
    while (frame_cnt < target)
      @(negedge clk);
  endtask

  // beam process acts on negedges only
  task automatic set_scan_mode(input int m);
    @(posedge clk);
    scan_mode = m;
  endtask

  // ----------------------------------------------------------------------
  // beam source and overlay checker
  // ----------------------------------------------------------------------

  initial begin : beam
    int          blank_cnt;
    int          vline;
    int          exp_w;
    logic [10:0] raddr;
    logic        exp_bit;
    blank_cnt = 0;
    wait (reset == 1'b0);
    forever begin
      for (int l = 0; l < frame_lines; l++) begin
        for (int c = 0; c < line_cycles; c++) begin
          @(negedge clk);
          if (c == 0) begin
            blank_cnt = 0;
            // mode follows the frame, like the enable latch
            if (l == 0) begin
              frame_mode = scan_mode;
              frame_cnt++;
            end
          end
          sol = (c == 0);
          sof = (c == 0) && (l == 0);
          // blank and pixel lag the beam count by two cycles
          if (osd_blank !== 1'b0) begin
            if (frame_mode == 1 && l >= win_v_start && l < win_v_start + win_height) begin
              vline   = l - win_v_start;
              raddr   = {vline[5:3], blank_cnt[7:0]};
              exp_bit = exp_buf[raddr][vline[2:0]];
              if (osd_pixel !== exp_bit) begin
                pixel_errors++;
                if (pixel_errors <= 20)
                  $display("mismatch pixel line %0d x %0d: expected %b actual %b",
                           vline, blank_cnt, exp_bit, osd_pixel);
              end
            end
            blank_cnt++;
          end
          // window width per line
          if (c == line_cycles - 1 && frame_mode != 2) begin
            if (frame_mode == 1 && l >= win_v_start && l < win_v_start + win_height)
              exp_w = win_width;
            else
              exp_w = 0;
            if (blank_cnt != exp_w) begin
              blank_errors++;
              if (blank_errors <= 20)
                $display("mismatch blank_width line %0d: expected %0d actual %0d",
                         l, exp_w, blank_cnt);
            end
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------

  initial begin : main
    logic [10:0] start;
    reset        = 1'b1;
    spi_cs_n     = 1'b1;
    spi_sck      = 1'b0;
    spi_sdi      = 1'b0;
    sol          = 1'b0;
    sof          = 1'b0;
    reg_errors   = 0;
    pixel_errors = 0;
    blank_errors = 0;
    scan_mode    = 0;
    frame_mode   = 0;
    frame_cnt    = 0;
    row_cnt      = 0;
    rng          = 32'd27326;

    // name, command, data bytes, count, expected field
    add_row("reset_ctrl", 8'h08, 8'h01, 8'h00, 1, 8'h01);
    add_row("osd_ctrl", 8'h48, 8'h02, 8'h00, 1, 8'h02);
    add_row("chipset", 8'h04, 8'hf5, 8'h00, 1, 8'h15);
    // low command bits set, still the memory code
    add_row("memory", 8'h27, 8'hda, 8'h00, 1, 8'h5a);
    add_row("video", 8'h34, 8'hb4, 8'h00, 1, 8'hb4);
    add_row("floppy", 8'h44, 8'h3c, 8'h00, 1, 8'h0c);
    add_row("chipset_second_byte", 8'h04, 8'h0a, 8'h1f, 2, 8'h0a);
    add_row("unknown_cmd", 8'hfc, 8'hff, 8'hff, 2, 8'h00);
    add_row("reset_ctrl_clear", 8'h08, 8'h00, 8'h01, 2, 8'h00);
    // address 0x5a3, then the payload fills the whole buffer
    add_row("buf_write", 8'h0c, 8'h05, 8'ha3, 2, 8'h00);

    repeat (16) @(negedge clk);
    reset = 1'b0;

    // only memory_config leaves reset nonzero
    cfg_exp = {8'd0, 7'b0000101, 12'd0};
    repeat (2) @(negedge clk);
    check_config("reset_values", cfg_exp);
    // one whole frame with blank low
    wait_frames(2);

    for (int r = 0; r < row_cnt; r++) begin
      spi_select();
      spi_byte(row_cmd[r]);
      spi_byte(row_d0[r]);
      if (row_len[r] > 1)
        spi_byte(row_d1[r]);
      if (row_cmd[r][7:2] == 6'b000011) begin
        start = {row_d0[r][2:0], row_d1[r]};
        write_payload(start);
      end
      spi_deselect();
      cfg_exp = apply_field(cfg_exp, row_cmd[r], row_exp[r]);
      check_config(row_name[r], cfg_exp);
    end

    // enable, skip the frame it lands in, then scan one full frame
    set_scan_mode(2);
    send_reg("osd_enable_on", 8'h48, 8'h01, 8'h01);
    wait_frames(1);
    set_scan_mode(1);
    wait_frames(2);

    // disable early in a frame, window still expected until next sof
    send_reg("osd_enable_off", 8'h48, 8'h00, 8'h00);
    set_scan_mode(0);
    wait_frames(2);

    $display("errors: registers %0d, pixels %0d, blank width %0d",
             reg_errors, pixel_errors, blank_errors);
    if (reg_errors + pixel_errors + blank_errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: test sequence did not finish within %0d cycles", watchdog_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* common/osd_pkg.sv */
// osd controller shared definitions: window geometry, widths, command codes and decoder phases
package osd_pkg;

  // ----------------------------------------------------------------------
  // window geometry
  // ----------------------------------------------------------------------

  // first horizontal beam count inside the window
  localparam int unsigned osd_h_start = 448;
  // window width in pixels
  localparam int unsigned osd_width = 256;
  // first vertical beam line inside the window
  localparam int unsigned osd_v_start = 128;
  // 8 text rows of 8 lines each
  localparam int unsigned osd_height = 64;

  // ----------------------------------------------------------------------
  // counter and buffer widths
  // ----------------------------------------------------------------------

  // horizontal beam counter
  localparam int unsigned hbeam_w = 11;
  // vertical beam counter
  localparam int unsigned vbeam_w = 9;
  // character buffer address, row in 10:8 and column in 7:0
  localparam int unsigned buf_addr_w = 11;
  localparam int unsigned buf_depth = 2048;

  // memory_config after reset
  localparam logic [6:0] mem_cfg_reset = 7'b0000101;

  // ----------------------------------------------------------------------
  // spi commands, bits 7:2 of the first byte in a frame
  // ----------------------------------------------------------------------

  typedef enum logic [5:0] {
    // no command, also used for any unknown code
    cmd_none       = 6'b000000,
    // register writes, one data byte each
    cmd_reset_ctrl = 6'b000010,
    cmd_osd_ctrl   = 6'b010010,
    cmd_chipset    = 6'b000001,
    cmd_memory     = 6'b001001,
    cmd_video      = 6'b001101,
    cmd_floppy     = 6'b010001,
    // two address bytes, then any number of data bytes
    cmd_buf_write  = 6'b000011
  } osd_cmd_e;

  // decoder phase within one spi frame
  typedef enum logic [2:0] {
    st_idle,
    st_reg_data,
    st_addr_hi,
    st_addr_lo,
    st_buf_data,
    st_ignore
  } dec_state_e;

endpackage

/* logic/osd_ctrl.sv */
// osd controller top: spi receiver, command decoder and video overlay
`timescale 1ns/1ns

module osd_ctrl (
  input  logic       clk,
  input  logic       reset,
  input  logic       spi_cs_n,
  input  logic       spi_sck,
  input  logic       spi_sdi,
  input  logic       sol,
  input  logic       sof,
  output logic       usrrst,
  output logic       osd_enable,
  output logic       key_disable,
  output logic [4:0] chipset_config,
  output logic [6:0] memory_config,
  output logic [1:0] scanline,
  output logic [1:0] lr_filter,
  output logic [1:0] hr_filter,
  output logic [1:0] dither,
  output logic [3:0] floppy_config,
  output logic       osd_blank,
  output logic       osd_pixel
);

  import osd_pkg::*;

  // receiver to decoder
  logic                  rx_valid;
  logic [7:0]            rx_byte;
  logic                  rx_is_cmd;
  logic                  frame_end;

  // decoder to buffer
  logic                  buf_we;
  logic [buf_addr_w-1:0] buf_waddr;
  logic [7:0]            buf_wdata;

  // beam timing to pixel output
  logic                  in_window;
  logic [buf_addr_w-1:0] buf_raddr;
  logic [2:0]            line_sel;

  // ----------------------------------------------------------------------
  // spi side
  // ----------------------------------------------------------------------

  spi_byte_rx u_spi_byte_rx (
    .clk       (clk),
    .reset     (reset),
    .spi_cs_n  (spi_cs_n),
    .spi_sck   (spi_sck),
    .spi_sdi   (spi_sdi),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .rx_is_cmd (rx_is_cmd),
    .frame_end (frame_end)
  );

  osd_cmd_decoder u_osd_cmd_decoder (
    .clk            (clk),
    .reset          (reset),
    .rx_valid       (rx_valid),
    .rx_byte        (rx_byte),
    .rx_is_cmd      (rx_is_cmd),
    .frame_end      (frame_end),
    .usrrst         (usrrst),
    .osd_enable     (osd_enable),
    .key_disable    (key_disable),
    .chipset_config (chipset_config),
    .memory_config  (memory_config),
    .scanline       (scanline),
    .lr_filter      (lr_filter),
    .hr_filter      (hr_filter),
    .dither         (dither),
    .floppy_config  (floppy_config),
    .buf_we         (buf_we),
    .buf_waddr      (buf_waddr),
    .buf_wdata      (buf_wdata)
  );

  // ----------------------------------------------------------------------
  // video side
  // ----------------------------------------------------------------------

  osd_beam_timing u_osd_beam_timing (
    .clk        (clk),
    .reset      (reset),
    .sol        (sol),
    .sof        (sof),
    .osd_enable (osd_enable),
    .in_window  (in_window),
    .buf_raddr  (buf_raddr),
    .line_sel   (line_sel)
  );

  osd_pixel_out u_osd_pixel_out (
    .clk       (clk),
    .in_window (in_window),
    .buf_raddr (buf_raddr),
    .line_sel  (line_sel),
    .buf_we    (buf_we),
    .buf_waddr (buf_waddr),
    .buf_wdata (buf_wdata),
    .osd_blank (osd_blank),
    .osd_pixel (osd_pixel)
  );

endmodule

/* osd_ctrl.f */
common/osd_pkg.sv
spi_cmd/spi_byte_rx.sv
spi_cmd/osd_cmd_decoder.sv
osd_video/osd_beam_timing.sv
osd_video/osd_pixel_out.sv
logic/osd_ctrl.sv
bench/osd_ctrl_tb.sv

/* osd_video/osd_beam_timing.sv */
// osd beam timing: beam counters, window detection and buffer read address
`timescale 1ns/1ns

module osd_beam_timing (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          sol,
  input  logic                          sof,
  input  logic                          osd_enable,
  output logic                          in_window,
  output logic [osd_pkg::buf_addr_w-1:0] buf_raddr,
  output logic [2:0]                    line_sel
);

  import osd_pkg::*;

  logic [hbeam_w-1:0] hcount;
  logic [vbeam_w-1:0] vcount;
  // enable as seen by the current frame
  logic               enable_q;

  logic               h_in;
  logic               v_in;
  logic [hbeam_w-1:0] h_off;
  logic [vbeam_w-1:0] v_off;

  // ----------------------------------------------------------------------
  // beam counters
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      hcount <= '0;
      vcount <= '0;
    end else begin
      // zero in the cycle after sol
      if (sol)
        hcount <= '0;
      else
        hcount <= hcount + 1'b1;
      // sof wins over sol on the first line
      if (sof)
        vcount <= '0;
      else if (sol)
        vcount <= vcount + 1'b1;
    end
  end

  // enable change only takes effect at frame start
  always_ff @(posedge clk) begin
    if (reset)
      enable_q <= 1'b0;
    else if (sof)
      enable_q <= osd_enable;
  end

  // ----------------------------------------------------------------------
  // window
  // ----------------------------------------------------------------------

  assign h_in = (hcount >= osd_h_start) && (hcount < osd_h_start + osd_width);
  assign v_in = (vcount >= osd_v_start) && (vcount < osd_v_start + osd_height);

  assign in_window = h_in & v_in & enable_q;

  // position relative to the window corner
  assign h_off = hcount - hbeam_w'(osd_h_start);
  assign v_off = vcount - vbeam_w'(osd_v_start);

  // text row on top, column below
  assign buf_raddr = {v_off[5:3], h_off[7:0]};
  // pixel line within the character
  assign line_sel  = v_off[2:0];

endmodule

/* osd_video/osd_pixel_out.sv */
// osd pixel output with the character buffer memory and pixel serialization
`timescale 1ns/1ns

module osd_pixel_out (
  input  logic                          clk,
  input  logic                          in_window,
  input  logic [osd_pkg::buf_addr_w-1:0] buf_raddr,
  input  logic [2:0]                    line_sel,
  input  logic                          buf_we,
  input  logic [osd_pkg::buf_addr_w-1:0] buf_waddr,
  input  logic [7:0]                    buf_wdata,
  output logic                          osd_blank,
  output logic                          osd_pixel
);

  import osd_pkg::*;

  // simple dual-port block ram
  logic [7:0] char_buf [buf_depth];

  logic [7:0] rd_data;
  // window and line delayed to match the read
  logic       win_q;
  logic [2:0] line_q;

  // ----------------------------------------------------------------------
  // buffer write port fed by the decoder
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (buf_we)
      char_buf[buf_waddr] <= buf_wdata;
  end

  // ----------------------------------------------------------------------
  // buffer read port used on every cycle
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    rd_data <= char_buf[buf_raddr];
  end

  // delay stage beside the read port
  always_ff @(posedge clk) begin
    win_q  <= in_window;
    line_q <= line_sel;
  end

  // ----------------------------------------------------------------------
  // outputs
  // ----------------------------------------------------------------------

  // overlay region one cycle behind the beam
  assign osd_blank = win_q;

  // bit per line within the character byte
  assign osd_pixel = win_q & rd_data[line_q];

endmodule

/* spi_cmd/osd_cmd_decoder.sv */
// osd command decoder: configuration registers and character buffer write strobes
`timescale 1ns/1ns

module osd_cmd_decoder (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          rx_valid,
  input  logic [7:0]                    rx_byte,
  input  logic                          rx_is_cmd,
  input  logic                          frame_end,
  output logic                          usrrst,
  output logic                          osd_enable,
  output logic                          key_disable,
  output logic [4:0]                    chipset_config,
  output logic [6:0]                    memory_config,
  output logic [1:0]                    scanline,
  output logic [1:0]                    lr_filter,
  output logic [1:0]                    hr_filter,
  output logic [1:0]                    dither,
  output logic [3:0]                    floppy_config,
  output logic                          buf_we,
  output logic [osd_pkg::buf_addr_w-1:0] buf_waddr,
  output logic [7:0]                    buf_wdata
);

  import osd_pkg::*;

  dec_state_e              state;
  osd_cmd_e                cmd_q;
  // next buffer address, advances after each data byte
  logic [buf_addr_w-1:0]   addr_q;

  // ----------------------------------------------------------------------
  // phase tracking and register loads
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= st_idle;
      cmd_q          <= cmd_none;
      usrrst         <= 1'b0;
      osd_enable     <= 1'b0;
      key_disable    <= 1'b0;
      chipset_config <= '0;
      memory_config  <= mem_cfg_reset;
      {dither, hr_filter, lr_filter, scanline} <= '0;
      floppy_config  <= '0;
      buf_we         <= 1'b0;
    end else begin
      buf_we <= 1'b0;
      if (frame_end) begin
        state <= st_idle;
      end else if (rx_valid && rx_is_cmd) begin
        // opcode sits in bits 7:2
        case (rx_byte[7:2])
          cmd_reset_ctrl, cmd_osd_ctrl, cmd_chipset,
          cmd_memory, cmd_video, cmd_floppy: begin
            cmd_q <= osd_cmd_e'(rx_byte[7:2]);
            state <= st_reg_data;
          end
          cmd_buf_write: begin
            cmd_q <= cmd_buf_write;
            state <= st_addr_hi;
          end
          default: begin
            cmd_q <= cmd_none;
            state <= st_ignore;
          end
        endcase
      end else if (rx_valid) begin
        case (state)
          st_reg_data: begin
            // only the first data byte counts
            case (cmd_q)
              cmd_reset_ctrl: usrrst <= rx_byte[0];
              cmd_osd_ctrl:   {key_disable, osd_enable} <= rx_byte[1:0];
              cmd_chipset:    chipset_config <= rx_byte[4:0];
              cmd_memory:     memory_config <= rx_byte[6:0];
              cmd_video:      {dither, hr_filter, lr_filter, scanline} <= rx_byte;
              cmd_floppy:     floppy_config <= rx_byte[3:0];
              default:        ;
            endcase
            state <= st_ignore;
          end
          st_addr_hi:  state <= st_addr_lo;
          st_addr_lo:  state <= st_buf_data;
          // one write per data byte
          st_buf_data: buf_we <= 1'b1;
          default:     ;
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // buffer address and write data
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rx_valid && !rx_is_cmd) begin
      case (state)
        // row bits of the start address
        st_addr_hi: addr_q[10:8] <= rx_byte[2:0];
        st_addr_lo: addr_q[7:0] <= rx_byte;
        st_buf_data: begin
          buf_waddr <= addr_q;
          buf_wdata <= rx_byte;
          // wraps at the end of the buffer
          addr_q    <= addr_q + 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

/* spi_cmd/spi_byte_rx.sv */
// spi byte receiver that synchronizes the spi pins and assembles msb-first bytes
`timescale 1ns/1ns

module spi_byte_rx (
  input  logic       clk,
  input  logic       reset,
  input  logic       spi_cs_n,
  input  logic       spi_sck,
  input  logic       spi_sdi,
  output logic       rx_valid,
  output logic [7:0] rx_byte,
  output logic       rx_is_cmd,
  output logic       frame_end
);

  // two-flop synchronizers plus a third sck and cs stage for edge detection
  logic [1:0] sck_sync;
  logic [1:0] sdi_sync;
  logic [1:0] cs_sync;
  logic       sck_d;
  logic       cs_d;

  logic       sck_rise;
  logic [2:0] bit_cnt;
  logic [7:0] shift_q;
  // set until the first byte of a frame completes
  logic       first_q;

  // ----------------------------------------------------------------------
  // pin synchronization
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    sck_sync <= {sck_sync[0], spi_sck};
    sdi_sync <= {sdi_sync[0], spi_sdi};
    cs_sync  <= {cs_sync[0], spi_cs_n};
    sck_d    <= sck_sync[1];
    cs_d     <= cs_sync[1];
  end

  // sample point where sdi_sync[1] lines up with the edge
  assign sck_rise = sck_sync[1] & ~sck_d;

  // ----------------------------------------------------------------------
  // byte assembly
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    // incoming data bits
    if (sck_rise && !cs_sync[1])
      shift_q <= {shift_q[6:0], sdi_sync[1]};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt   <= '0;
      first_q   <= 1'b1;
      rx_valid  <= 1'b0;
      rx_is_cmd <= 1'b0;
      frame_end <= 1'b0;
    end else begin
      rx_valid  <= 1'b0;
      // cs rising edge closes the frame
      frame_end <= cs_sync[1] & ~cs_d;
      if (cs_sync[1]) begin
        // re-arm for the next frame while deselected
        bit_cnt <= '0;
        first_q <= 1'b1;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          rx_valid  <= 1'b1;
          rx_is_cmd <= first_q;
          first_q   <= 1'b0;
        end
      end
    end
  end

  // held until the next sck edge
  assign rx_byte = shift_q;

endmodule
